/* pdp8_macros.svh */
`ifndef PDP8_MACROS_SVH
`define PDP8_MACROS_SVH

// word and address sizes of the single 4K field
`define PDP8_WORD_W 12
`define PDP8_ADDR_W 12
`define PDP8_MEM_DEPTH 4096

// extra cycles per memory read, must be 1 or more
`define PDP8_MEM_WAIT 2

// auto-index locations on page zero
`define PDP8_AUTOINDEX_LO 12'o0010
`define PDP8_AUTOINDEX_HI 12'o0017

`endif

/* pdp8_pkg.sv */
`include "pdp8_macros.svh"

package pdp8_pkg;

  typedef enum logic [4:0] {
    H0, HW, H1, H2,      // halt and front panel
    F0, FW, F1, F2, F3,  // fetch
    D0, DW, D1, D2,      // defer
    E0, EW, E1, E2, E3   // execute
  } major_state_t;

  // top three bits of an instruction word
  typedef enum logic [2:0] {
    AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR
  } opcode_t;

  typedef struct packed {
    logic [`PDP8_WORD_W-1:0] sr;
    logic load_addr;
    logic deposit;
    logic examine;
    logic cont;
  } panel_t;

  typedef struct packed {
    logic [`PDP8_WORD_W-1:0] pc;
    logic [`PDP8_WORD_W-1:0] ac;
    logic link;
    logic running;
    logic [`PDP8_WORD_W-1:0] mdout;
  } core_status_t;

  // states that hold while a memory read settles
  function automatic logic is_wait_state(major_state_t s);
    return s inside {FW, DW, EW, HW};
  endfunction

  // opcodes 0 to 5 carry an operand address
  function automatic logic is_mem_ref(opcode_t op);
    return op inside {AND, TAD, ISZ, DCA, JMS, JMP};
  endfunction

endpackage

/* pdp8_ram.sv */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module pdp8_ram (
  input  logic                    clk,
  input  logic [`PDP8_ADDR_W-1:0] addr,
  input  logic [`PDP8_WORD_W-1:0] din,
  input  logic                    write_en,
  output logic [`PDP8_WORD_W-1:0] dout
);

  logic [`PDP8_WORD_W-1:0] mem [`PDP8_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];  // old word on a write cycle
  end

  // a write to an unknown location would corrupt the whole array in gate sims
  a_write_addr_known: assert property (
    @(posedge clk) write_en |-> !$isunknown(addr)
  );

endmodule

/* mem_wait_timer.sv */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module mem_wait_timer import pdp8_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  major_state_t state,
  output logic         mem_ready
);

  localparam int CNT_W = $clog2(`PDP8_MEM_WAIT + 1);
  localparam logic [CNT_W-1:0] LOAD = CNT_W'(`PDP8_MEM_WAIT - 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= LOAD;
    end else if (!is_wait_state(state)) begin
      count <= LOAD;  // rearm outside the wait states
    end else if (count != '0) begin
      count <= count - CNT_W'(1);
    end
  end

  assign mem_ready = is_wait_state(state) && (count == '0);

  // sequencer must leave the wait state right after ready
  a_ready_one_cycle: assert property (
    @(posedge clk) disable iff (reset) mem_ready |=> !mem_ready
  );

endmodule

/* major_state_fsm.sv */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module major_state_fsm import pdp8_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  panel_t                  panel,
  input  logic                    mem_ready,
  input  logic [`PDP8_WORD_W-1:0] instruction,
  output major_state_t            state,
  output logic                    running
);

  localparam logic [`PDP8_WORD_W-1:0] HLT_WORD = 12'o7402;

  major_state_t state_next;
  opcode_t      op;
  logic         is_hlt;
  logic         panel_req;

  assign op        = opcode_t'(instruction[11:9]);
  assign is_hlt    = (instruction == HLT_WORD);
  assign panel_req = panel.load_addr || panel.deposit || panel.examine;

  always_comb begin
    state_next = state;
    case (state)
      H0: begin
        if (panel.cont) begin
          state_next = F0;
        end else if (panel_req) begin
          state_next = HW;
        end
      end
      HW: if (mem_ready) state_next = H1;
      H1: state_next = H2;
      H2: state_next = H0;
      F0: state_next = FW;
      FW: if (mem_ready) state_next = F1;
      F1: state_next = F2;
      F2: state_next = F3;
      F3: begin
        if (is_hlt) begin
          state_next = H0;
        end else if (instruction[8] && is_mem_ref(op)) begin
          state_next = D0;  // indirect
        end else begin
          state_next = E0;
        end
      end
      D0: state_next = DW;
      DW: if (mem_ready) state_next = D1;
      D1: state_next = D2;
      D2: state_next = E0;
      E0: state_next = EW;
      EW: if (mem_ready) state_next = E1;
      E1: state_next = E2;
      E2: state_next = E3;
      E3: state_next = F0;
      default: state_next = H0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= H0;
      running <= 1'b0;
    end else begin
      state <= state_next;
      if (state == H0 && panel.cont) begin
        running <= 1'b1;
      end else if (state == F3 && is_hlt) begin
        running <= 1'b0;
      end
    end
  end

  a_halted_when_h: assert property (
    @(posedge clk) disable iff (reset) (state inside {H0, HW, H1, H2}) |-> !running
  );

  a_state_legal: assert property (
    @(posedge clk) disable iff (reset)
      !$isunknown(state) && (state inside {H0, HW, H1, H2, F0, FW, F1, F2, F3,
                                           D0, DW, D1, D2, E0, EW, E1, E2, E3})
  );

endmodule

/* mem_addr.sv */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module mem_addr import pdp8_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  major_state_t            state,
  input  logic [`PDP8_WORD_W-1:0] pc,
  input  logic [`PDP8_WORD_W-1:0] ac,
  input  logic [`PDP8_WORD_W-1:0] sr,
  input  logic                    load_addr,
  input  logic                    deposit,
  input  logic                    examine,
  input  logic [`PDP8_WORD_W-1:0] ram_dout,
  output logic [`PDP8_ADDR_W-1:0] ram_addr,
  output logic [`PDP8_WORD_W-1:0] ram_din,
  output logic                    ram_write_en,
  output logic [`PDP8_WORD_W-1:0] instruction,
  output logic [`PDP8_WORD_W-1:0] ma,
  output logic [`PDP8_WORD_W-1:0] mdout,
  output logic                    isz_skip
);

  opcode_t    op;
  logic       autoindex;
  logic [4:0] page;
  logic       op_load;  // panel request latched in H0
  logic       op_dep;
  logic       op_exam;

  assign op        = opcode_t'(instruction[11:9]);
  assign autoindex = (ma >= `PDP8_AUTOINDEX_LO) && (ma <= `PDP8_AUTOINDEX_HI);
  assign page      = instruction[7] ? ma[11:7] : 5'b00000;  // ma holds the fetch address

  // fetch reads at pc, everything else at ma
  assign ram_addr = (state == F0 || state == FW) ? pc : ma;

  always_ff @(posedge clk) begin
    if (reset) begin
      ma           <= '0;
      instruction  <= 12'o7000;
      isz_skip     <= 1'b0;
      ram_write_en <= 1'b0;
      op_load      <= 1'b0;
      op_dep       <= 1'b0;
      op_exam      <= 1'b0;
    end else begin
      ram_write_en <= 1'b0;
      case (state)
        F0: ma <= pc;
        FW: instruction <= ram_dout;
        F3: if (is_mem_ref(op)) ma <= {page, instruction[6:0]};
        D1: if (autoindex) ram_write_en <= 1'b1;  // bump pointer in place
        D2: ma <= autoindex ? mdout + 12'd1 : mdout;
        E1: begin
          case (op)
            ISZ: begin
              ram_write_en <= 1'b1;
              isz_skip     <= (mdout == 12'o7777);
            end
            DCA, JMS: ram_write_en <= 1'b1;
            default: ;
          endcase
        end
        E3: isz_skip <= 1'b0;
        H0: begin
          op_load <= load_addr;
          op_dep  <= deposit;
          op_exam <= examine;
        end
        H1: begin
          if (op_load) begin
            ma <= sr;
          end else if (op_dep) begin
            ram_write_en <= 1'b1;
          end
        end
        H2: if (op_dep || op_exam) ma <= ma + 12'd1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      FW, DW, EW, HW: mdout <= ram_dout;
      D1: ram_din <= mdout + 12'd1;
      E1: begin
        case (op)
          ISZ: ram_din <= mdout + 12'd1;
          DCA: ram_din <= ac;
          JMS: ram_din <= pc;  // already the return address
          default: ;
        endcase
      end
      H1: ram_din <= sr;
      default: ;
    endcase
  end

  // writes land one cycle after their state, never during a read wait
  a_no_write_in_wait: assert property (
    @(posedge clk) disable iff (reset) ram_write_en |-> !is_wait_state(state)
  );

endmodule

/* pdp8_arith.sv */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module pdp8_arith import pdp8_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  major_state_t            state,
  input  logic [`PDP8_WORD_W-1:0] instruction,
  input  logic [`PDP8_WORD_W-1:0] ma,
  input  logic [`PDP8_WORD_W-1:0] mdout,
  input  logic                    isz_skip,
  input  logic                    load_addr,
  output logic [`PDP8_WORD_W-1:0] pc,
  output logic [`PDP8_WORD_W-1:0] ac,
  output logic                    link
);

  opcode_t               op;
  logic [`PDP8_WORD_W:0] tad_sum;
  logic                  load_pend;

  assign op      = opcode_t'(instruction[11:9]);
  assign tad_sum = {1'b0, ac} + {1'b0, mdout};

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      ac        <= '0;
      link      <= 1'b0;
      load_pend <= 1'b0;
    end else begin
      case (state)
        H0: load_pend <= load_addr;
        H2: if (load_pend) pc <= ma;  // ma took sr in H1
        F1: pc <= pc + 12'd1;
        E2: begin
          case (op)
            AND: ac <= ac & mdout;
            TAD: begin
              ac   <= tad_sum[`PDP8_WORD_W-1:0];
              link <= link ^ tad_sum[`PDP8_WORD_W];  // carry flips link
            end
            DCA: ac <= '0;
            JMP: pc <= ma;
            JMS: pc <= ma + 12'd1;
            default: ;
          endcase
        end
        E3: pc <= pc + {{(`PDP8_WORD_W-1){1'b0}}, isz_skip};
        default: ;
      endcase
    end
  end

endmodule

/* pdp8_core.sv */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module pdp8_core import pdp8_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  panel_t       panel,
  output core_status_t status
);

  major_state_t            state;
  logic                    mem_ready;
  logic                    running;
  logic [`PDP8_ADDR_W-1:0] ram_addr;
  logic [`PDP8_WORD_W-1:0] ram_din;
  logic [`PDP8_WORD_W-1:0] ram_dout;
  logic                    ram_write_en;
  logic [`PDP8_WORD_W-1:0] instruction;
  logic [`PDP8_WORD_W-1:0] ma;
  logic [`PDP8_WORD_W-1:0] mdout;
  logic                    isz_skip;
  logic [`PDP8_WORD_W-1:0] pc;
  logic [`PDP8_WORD_W-1:0] ac;
  logic                    link;

  pdp8_ram u_ram (
    .clk(clk), .addr(ram_addr), .din(ram_din), .write_en(ram_write_en), .dout(ram_dout)
  );

  mem_wait_timer u_timer (.clk(clk), .reset(reset), .state(state), .mem_ready(mem_ready));

  major_state_fsm u_fsm (
    .clk(clk), .reset(reset), .panel(panel), .mem_ready(mem_ready),
    .instruction(instruction), .state(state), .running(running)
  );

  mem_addr u_mem_addr (
    .clk(clk), .reset(reset), .state(state), .pc(pc), .ac(ac), .sr(panel.sr),
    .load_addr(panel.load_addr), .deposit(panel.deposit), .examine(panel.examine),
    .ram_dout(ram_dout), .ram_addr(ram_addr), .ram_din(ram_din),
    .ram_write_en(ram_write_en), .instruction(instruction), .ma(ma), .mdout(mdout),
    .isz_skip(isz_skip)
  );

  pdp8_arith u_arith (
    .clk(clk), .reset(reset), .state(state), .instruction(instruction), .ma(ma),
    .mdout(mdout), .isz_skip(isz_skip), .load_addr(panel.load_addr),
    .pc(pc), .ac(ac), .link(link)
  );

  assign status = '{pc: pc, ac: ac, link: link, running: running, mdout: mdout};

endmodule

/* tb_pdp8_core.sv */
`timescale 1ns/1ps
`include "pdp8_macros.svh"

module tb_pdp8_core import pdp8_pkg::*; ();

  localparam int LOAD = 0;
  localparam int DEP  = 1;
  localparam int EXAM = 2;

  logic         clk;
  logic         reset;
  panel_t       panel;
  core_status_t status;

  logic [11:0] ref_mem [4096];
  logic [11:0] ref_ac;
  logic [11:0] ref_pc;
  logic        ref_link;
  logic [15:0] lfsr;
  int          errors;
  int          cycles;
  int          cycle_limit;

  pdp8_core u_pdp8_core (.clk(clk), .reset(reset), .panel(panel), .status(status));

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: core did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_random(output logic [11:0] w);
    w = '0;
    for (int b = 0; b < 12; b++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[10:0], lfsr[15]};  // one step per bit
    end
  endtask

  // instruction-level model, runs until HLT and returns the instruction count
  function automatic int interpret(input logic [11:0] start);
    logic [11:0] pc;
    logic [11:0] ir;
    logic [11:0] ea;
    logic [12:0] sum;
    int          n;
    pc = start;
    n = 0;
    while (n < 1000) begin
      ir = ref_mem[pc];
      ea = {ir[7] ? pc[11:7] : 5'b00000, ir[6:0]};  // page of the fetch address
      pc = pc + 12'd1;
      n++;
      if (ir == 12'o7402) break;
      if (ir[11:9] <= 3'd5) begin
        if (ir[8]) begin
          if (ea >= 12'o0010 && ea <= 12'o0017) ref_mem[ea] = ref_mem[ea] + 12'd1;
          ea = ref_mem[ea];
        end
        case (ir[11:9])
          3'd0: ref_ac = ref_ac & ref_mem[ea];
          3'd1: begin
            sum = {1'b0, ref_ac} + {1'b0, ref_mem[ea]};
            ref_ac = sum[11:0];
            ref_link = ref_link ^ sum[12];
          end
          3'd2: begin
            ref_mem[ea] = ref_mem[ea] + 12'd1;
            if (ref_mem[ea] == 12'd0) pc = pc + 12'd1;
          end
          3'd3: begin
            ref_mem[ea] = ref_ac;
            ref_ac = '0;
          end
          3'd4: begin
            ref_mem[ea] = pc;
            pc = ea + 12'd1;
          end
          default: pc = ea;
        endcase
      end
    end
    ref_pc = pc;
    return n;
  endfunction

  task automatic check(input string name, input logic [11:0] got, input logic [11:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %o, expected %o", $time, name, got, exp);
    end
  endtask

  // one panel strobe, returns once the core is back in H0
  task automatic panel_op(input int kind, input logic [11:0] value);
    @(posedge clk);
    #1;
    panel.sr = value;
    panel.load_addr = (kind == LOAD);
    panel.deposit   = (kind == DEP);
    panel.examine   = (kind == EXAM);
    @(posedge clk);
    #1;
    panel.load_addr = 1'b0;
    panel.deposit   = 1'b0;
    panel.examine   = 1'b0;
    repeat (`PDP8_MEM_WAIT + 2) @(posedge clk);
    #1;
  endtask

  task automatic put(input logic [11:0] addr, input logic [11:0] word);
    ref_mem[addr] = word;
    panel_op(LOAD, addr);
    panel_op(DEP, word);
  endtask

  task automatic examine_at(input logic [11:0] addr, input string name);
    panel_op(LOAD, addr);
    panel_op(EXAM, 12'd0);
    check(name, status.mdout, ref_mem[addr]);
  endtask

  task automatic run_program(input logic [11:0] start);
    cycle_limit += 40 * interpret(start);
    panel_op(LOAD, start);
    @(posedge clk);
    #1 panel.cont = 1'b1;
    @(posedge clk);
    #1 panel.cont = 1'b0;
    check("running", 12'(status.running), 12'd1);
    while (status.running) begin
      @(posedge clk);
      #1;
    end
    check("ac", status.ac, ref_ac);
    check("link", 12'(status.link), 12'(ref_link));
    check("pc", status.pc, ref_pc);
  endtask

  initial begin
    logic [11:0] w;
    logic [11:0] a;
    clk = 1'b0;
    reset = 1'b1;
    panel = '0;
    lfsr = 16'd70;
    errors = 0;
    cycles = 0;
    cycle_limit = 2000;
    ref_ac = '0;
    ref_link = 1'b0;

    // cont during reset must not start the core
    repeat (10) @(posedge clk);
    #1 panel.cont = 1'b1;
    @(posedge clk);
    #1 panel.cont = 1'b0;
    check("running", 12'(status.running), 12'd0);
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    check("running", 12'(status.running), 12'd0);
    @(posedge clk);
    #1;
    check("running", 12'(status.running), 12'd0);
    check("pc", status.pc, 12'd0);
    ref_mem[0] = 12'o5252;
    panel_op(DEP, 12'o5252);  // ma is 0 out of reset
    examine_at(12'd0, "mdout at 0");

    // deposit then examine a block
    panel_op(LOAD, 12'o2000);
    for (a = 12'o2000; a < 12'o2020; a++) begin
      next_random(w);
      ref_mem[a] = w;
      panel_op(DEP, w);
    end
    panel_op(LOAD, 12'o2000);
    for (a = 12'o2000; a < 12'o2020; a++) begin
      panel_op(EXAM, 12'd0);
      check("mdout", status.mdout, ref_mem[a]);
      check("pc", status.pc, 12'o2000);
    end

    // page zero and current page on page 5
    put(12'o0050, 12'o0000);
    next_random(w);
    put(12'o0051, w);
    put(12'o0052, 12'o0707);
    next_random(w);
    put(12'o1220, w);
    next_random(w);
    put(12'o1222, w);
    put(12'o1223, 12'o6543);
    put(12'o1200, 12'o0050);
    put(12'o1201, 12'o1220);
    put(12'o1202, 12'o1051);
    put(12'o1203, 12'o3221);
    put(12'o1204, 12'o1222);
    put(12'o1205, 12'o0052);
    put(12'o1206, 12'o3053);
    put(12'o1207, 12'o1223);
    put(12'o1210, 12'o1223);
    put(12'o1211, 12'o7402);
    run_program(12'o1200);
    examine_at(12'o1221, "mem 1221");
    examine_at(12'o0053, "mem 0053");

    // indirect through auto-index 0010
    for (a = 12'o0300; a < 12'o0303; a++) begin
      next_random(w);
      put(a, w);
    end
    put(12'o0010, 12'o0277);
    put(12'o0400, 12'o0050);
    put(12'o0401, 12'o1410);
    put(12'o0402, 12'o1410);
    put(12'o0403, 12'o1410);
    put(12'o0404, 12'o7402);
    run_program(12'o0400);
    examine_at(12'o0010, "mem 0010");
    check("pointer", status.mdout, 12'o0302);

    // ISZ loop, three passes
    put(12'o0054, 12'o7775);
    put(12'o0055, 12'o0011);
    put(12'o0600, 12'o0050);
    put(12'o0601, 12'o1055);
    put(12'o0602, 12'o2054);
    put(12'o0603, 12'o5201);
    put(12'o0604, 12'o3056);
    put(12'o0605, 12'o7402);
    run_program(12'o0600);
    examine_at(12'o0054, "mem 0054");
    examine_at(12'o0056, "mem 0056");
    check("loop sum", status.mdout, 12'o0033);

    // subroutine call and indirect return
    put(12'o1000, 12'o0050);
    put(12'o1001, 12'o4220);
    put(12'o1002, 12'o7402);
    put(12'o1020, 12'o0000);
    put(12'o1021, 12'o1051);
    put(12'o1022, 12'o5620);
    run_program(12'o1000);
    examine_at(12'o1020, "mem 1020");
    check("return addr", status.mdout, 12'o1002);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
pdp8_pkg.sv
pdp8_ram.sv
mem_wait_timer.sv
major_state_fsm.sv
mem_addr.sv
pdp8_arith.sv
pdp8_core.sv
tb_pdp8_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_pdp8_core -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
